//--- mul_pkg.sv
// Unsigned only; widths fixed at 64x64 into a 136-bit accumulator; two sources share one result port
package mul_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W      = 64;   // Operand and result width
  localparam int PROD_W      = 128;  // Full product width
  localparam int ACC_W       = 136;  // Accumulator with MAC headroom
  localparam int MUL_LAT     = 3;    // Issue to result, cycles
  localparam int REQ_DEPTH   = 2;    // Entries per request queue
  localparam int RES_CREDITS = 4;    // Result credits held after reset

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // SPU operation
  typedef enum logic [1:0] {
    OP_MUL   = 2'd0,  // Plain product
    OP_MAC   = 2'd1,  // Accumulate product
    OP_RDSHF = 2'd2,  // Read low 64, shift right by 64
    OP_CLR   = 2'd3   // Clear accumulator
  } mul_op_e;

  // Result tag
  typedef enum logic {
    SRC_EXU = 1'b0,
    SRC_SPU = 1'b1
  } src_e;

  ////////////////////////////////////////////////////////////
  // Request payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;
  } exu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;  // Ignored when byp is set
    mul_op_e           op;
    logic              x2;   // Double the product
    logic              byp;  // Take op2 from accumulator low half
  } spu_req_t;

endpackage

//--- mul_req_fifo.sv
// Requester must hold a credit to push; one credit pulse follows each pop, never on the pop cycle
`timescale 1ns/1ns

module mul_req_fifo #(
  parameter type T = logic
) (
  input  logic rclk,
  input  logic rst_n,
  input  logic push,        // Requester valid
  input  T     din,
  input  logic pop,         // Head taken for issue
  output logic head_valid,
  output T     head,
  output logic credit       // One pulse per released entry
);

  import mul_pkg::*;

  localparam int PTR_W = $clog2(REQ_DEPTH);
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  T                 mem [REQ_DEPTH];  // Payload storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             credit_q;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Both or neither
      endcase
      credit_q <= pop;                    // Credit back the cycle after release
    end
  end

  always_ff @(posedge rclk) begin
    if (push) mem[wr_ptr] <= din;
  end

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign credit     = credit_q;

  // Credit protocol keeps the requester from overrunning the queue
  a_no_overflow : assert property (@(posedge rclk) disable iff (!rst_n)
    push |-> (count < CNT_W'(REQ_DEPTH)));

  // Control only releases a valid head
  a_no_underflow : assert property (@(posedge rclk) disable iff (!rst_n)
    pop |-> head_valid);

endmodule

//--- mul_ctl.sv
// Round-robin between EXU and SPU; SPU accumulator readers stall while any accumulator write is in flight
`timescale 1ns/1ns

module mul_ctl (
  input  logic              rclk,
  input  logic              rst_n,
  input  logic              exu_head_valid,
  input  logic              spu_head_valid,
  input  mul_pkg::spu_req_t spu_head,
  input  logic              res_credit,      // Consumer returns one result credit
  output logic              exu_pop,
  output logic              spu_pop,
  output logic              issue,           // Start of multiply, cycle 0
  output mul_pkg::src_e     issue_src,
  output mul_pkg::mul_op_e  issue_op,
  output logic              issue_x2,
  output logic              issue_byp,
  output logic              wb_valid,        // Writeback, MUL_LAT after issue
  output mul_pkg::src_e     wb_src,
  output mul_pkg::mul_op_e  wb_op
);

  import mul_pkg::*;

  localparam int CRD_W = $clog2(RES_CREDITS + 1);
  localparam int ACC_CNT_W = $clog2(MUL_LAT + 1);

  logic [CRD_W-1:0]     credits_q;     // Result credits held
  logic [ACC_CNT_W-1:0] acc_wr_cnt;    // Accumulator writers in flight
  logic                 rr_spu_pri;    // SPU wins the next tie
  logic                 acc_busy;
  logic                 spu_acc_rd;    // SPU head reads the accumulator
  logic                 exu_elig;
  logic                 spu_elig;
  logic                 pick_spu;
  logic                 issue_acc_wr;
  logic                 wb_acc_wr;
  logic [MUL_LAT-1:0]   vld_sr;        // Tag valid pipe
  src_e                 src_sr [MUL_LAT];
  mul_op_e              op_sr  [MUL_LAT];

  ////////////////////////////////////////////////////////////
  // Eligibility and pick
  ////////////////////////////////////////////////////////////

  assign acc_busy   = (acc_wr_cnt != '0);
  assign spu_acc_rd = spu_head.byp || (spu_head.op == OP_RDSHF) || (spu_head.op == OP_MAC);
  assign exu_elig   = exu_head_valid;
  assign spu_elig   = spu_head_valid && !(spu_acc_rd && acc_busy);

  assign pick_spu = spu_elig && (!exu_elig || rr_spu_pri);   // Tie goes to the pointer
  assign issue    = (credits_q != '0) && (exu_elig || spu_elig);
  assign exu_pop  = issue && !pick_spu;
  assign spu_pop  = issue && pick_spu;

  assign issue_src = pick_spu ? SRC_SPU : SRC_EXU;
  assign issue_op  = pick_spu ? spu_head.op : OP_MUL;        // EXU is always a plain multiply
  assign issue_x2  = pick_spu && spu_head.x2;
  assign issue_byp = pick_spu && spu_head.byp;

  // MAC, RDSHF and CLR all modify the accumulator
  assign issue_acc_wr = spu_pop && (spu_head.op != OP_MUL);
  assign wb_acc_wr    = wb_valid && (wb_src == SRC_SPU) && (wb_op != OP_MUL);

  ////////////////////////////////////////////////////////////
  // Pointer, credits, scoreboard
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      rr_spu_pri <= 1'b0;
      credits_q  <= CRD_W'(RES_CREDITS);
      acc_wr_cnt <= '0;
    end else begin
      if (issue) rr_spu_pri <= !pick_spu;   // Other side first next time
      case ({issue, res_credit})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
      case ({issue_acc_wr, wb_acc_wr})
        2'b10:   acc_wr_cnt <= acc_wr_cnt + 1'b1;
        2'b01:   acc_wr_cnt <= acc_wr_cnt - 1'b1;   // Drops after the acc has latched
        default: acc_wr_cnt <= acc_wr_cnt;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Tag pipe, aligned with the multiplier
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[MUL_LAT-2:0], issue};
    end
  end

  always_ff @(posedge rclk) begin
    src_sr[0] <= issue_src;
    op_sr[0]  <= issue_op;
    for (int i = 1; i < MUL_LAT; i++) begin
      src_sr[i] <= src_sr[i-1];
      op_sr[i]  <= op_sr[i-1];
    end
  end

  assign wb_valid = vld_sr[MUL_LAT-1];
  assign wb_src   = src_sr[MUL_LAT-1];
  assign wb_op    = op_sr[MUL_LAT-1];

  // Consumer never returns more credits than results it received
  a_crd_overflow : assert property (@(posedge rclk) disable iff (!rst_n)
    (res_credit && !issue) |-> (credits_q < CRD_W'(RES_CREDITS)));

  // Nothing issues without a result slot
  a_crd_underflow : assert property (@(posedge rclk) disable iff (!rst_n)
    issue |=> (credits_q <= CRD_W'(RES_CREDITS)) && !$isunknown(credits_q));

endmodule

//--- mul_core.sv
// Unsigned only; fixed three-cycle latency with no stall; doubling uses the extra top product bit
`timescale 1ns/1ns

module mul_core (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic [mul_pkg::DATA_W-1:0] op1,
  input  logic [mul_pkg::DATA_W-1:0] op2,
  input  logic                      x2,           // Double the product
  output logic                      prod_valid,
  output logic [mul_pkg::PROD_W:0]  prod          // One bit wider for x2
);

  import mul_pkg::*;

  localparam int HALF = DATA_W / 2;

  // Stage 1 operands
  logic                  v1;
  logic [DATA_W-1:0]     a_q;
  logic [DATA_W-1:0]     b_q;
  logic                  x2_1;
  // Stage 2 partial products
  logic                  v2;
  logic [DATA_W-1:0]     pp_ll;
  logic [DATA_W-1:0]     pp_lh;
  logic [DATA_W-1:0]     pp_hl;
  logic [DATA_W-1:0]     pp_hh;
  logic                  x2_2;
  // Stage 3 sum
  logic [PROD_W-1:0]     sum;
  logic [PROD_W:0]       prod_q;
  logic                  v3;

  ////////////////////////////////////////////////////////////
  // Valid pipe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      v1 <= in_valid;
      v2 <= v1;
      v3 <= v2;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data stages
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    // Stage 1 captures operands
    a_q  <= op1;
    b_q  <= op2;
    x2_1 <= x2;
    // Stage 2 forms 32x32 partials
    pp_ll <= a_q[HALF-1:0]      * b_q[HALF-1:0];
    pp_lh <= a_q[HALF-1:0]      * b_q[DATA_W-1:HALF];
    pp_hl <= a_q[DATA_W-1:HALF] * b_q[HALF-1:0];
    pp_hh <= a_q[DATA_W-1:HALF] * b_q[DATA_W-1:HALF];
    x2_2  <= x2_1;
    // Stage 3 sums and doubles
    prod_q <= x2_2 ? {sum, 1'b0} : {1'b0, sum};
  end

  // Cross terms land at bit 32, high term at bit 64
  assign sum = PROD_W'(pp_ll)
             + (PROD_W'(pp_lh) << HALF)
             + (PROD_W'(pp_hl) << HALF)
             + (PROD_W'(pp_hh) << DATA_W);

  assign prod_valid = v3;
  assign prod       = prod_q;

endmodule

//--- mul_dp.sv
// Bypass reads the accumulator at issue; control must hold off readers while a writer is in flight
`timescale 1ns/1ns

module mul_dp (
  input  logic                       rclk,
  input  logic                       rst_n,
  input  mul_pkg::src_e              issue_src,
  input  logic                       issue_byp,
  input  mul_pkg::exu_req_t          exu_head,
  input  mul_pkg::spu_req_t          spu_head,
  output logic [mul_pkg::DATA_W-1:0] mul_op1,
  output logic [mul_pkg::DATA_W-1:0] mul_op2,
  input  logic                       wb_valid,
  input  mul_pkg::src_e              wb_src,
  input  mul_pkg::mul_op_e           wb_op,
  input  logic [mul_pkg::PROD_W:0]   prod,
  output logic                       res_valid,
  output mul_pkg::src_e              res_src,
  output logic [mul_pkg::DATA_W-1:0] res_data
);

  import mul_pkg::*;

  logic [ACC_W-1:0] acc_q;       // Accumulator
  logic [ACC_W-1:0] acc_mac;     // Accumulator plus product
  logic [ACC_W-1:0] acc_next;
  logic             acc_wr;      // SPU writeback touching the acc
  logic             wb_spu;

  ////////////////////////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (issue_src == SRC_SPU) begin
      mul_op1 = spu_head.op1;
      mul_op2 = issue_byp ? acc_q[DATA_W-1:0] : spu_head.op2;  // Acc low half bypass
    end else begin
      mul_op1 = exu_head.op1;
      mul_op2 = exu_head.op2;
    end
  end

  ////////////////////////////////////////////////////////////
  // Accumulator update at writeback
  ////////////////////////////////////////////////////////////

  assign wb_spu  = wb_valid && (wb_src == SRC_SPU);
  assign acc_wr  = wb_spu && (wb_op != OP_MUL);
  assign acc_mac = acc_q + ACC_W'(prod);        // Wraps at ACC_W

  always_comb begin
    case (wb_op)
      OP_MAC:   acc_next = acc_mac;
      OP_RDSHF: acc_next = acc_q >> DATA_W;      // Zero fill from the top
      OP_CLR:   acc_next = '0;
      default:  acc_next = acc_q;
    endcase
  end

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (acc_wr) begin
      acc_q <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    res_data = prod[DATA_W-1:0];                 // EXU and SPU MUL
    if (wb_spu) begin
      case (wb_op)
        OP_MAC:   res_data = acc_mac[DATA_W-1:0];  // New low half
        OP_RDSHF: res_data = acc_q[DATA_W-1:0];    // Old low half
        OP_CLR:   res_data = '0;
        default:  res_data = prod[DATA_W-1:0];
      endcase
    end
  end

  assign res_valid = wb_valid;
  assign res_src   = wb_src;

endmodule

//--- mul_unit.sv
// Both requesters and the consumer use credits; one result per request, in order within a source
`timescale 1ns/1ns

module mul_unit (
  input  logic                       rclk,
  input  logic                       rst_n,
  // EXU request
  input  logic                       exu_valid,
  input  logic [mul_pkg::DATA_W-1:0] exu_op1,
  input  logic [mul_pkg::DATA_W-1:0] exu_op2,
  output logic                       exu_credit,
  // SPU request
  input  logic                       spu_valid,
  input  logic [mul_pkg::DATA_W-1:0] spu_op1,
  input  logic [mul_pkg::DATA_W-1:0] spu_op2,
  input  mul_pkg::mul_op_e           spu_op,
  input  logic                       spu_x2,
  input  logic                       spu_byp,
  output logic                       spu_credit,
  // Result
  output logic                       res_valid,
  output mul_pkg::src_e              res_src,
  output logic [mul_pkg::DATA_W-1:0] res_data,
  input  logic                       res_credit
);

  import mul_pkg::*;

  exu_req_t          exu_din;
  spu_req_t          spu_din;
  logic              exu_head_valid;
  logic              spu_head_valid;
  exu_req_t          exu_head;
  spu_req_t          spu_head;
  logic              exu_pop;
  logic              spu_pop;
  logic              issue;
  src_e              issue_src;
  logic              issue_x2;
  logic              issue_byp;
  logic [DATA_W-1:0] mul_op1;
  logic [DATA_W-1:0] mul_op2;
  logic [PROD_W:0]   prod;
  logic              wb_valid;
  src_e              wb_src;
  mul_op_e           wb_op;

  assign exu_din = '{op1: exu_op1, op2: exu_op2};
  assign spu_din = '{op1: spu_op1, op2: spu_op2, op: spu_op, x2: spu_x2, byp: spu_byp};

  ////////////////////////////////////////////////////////////
  // Request queues
  ////////////////////////////////////////////////////////////

  mul_req_fifo #(.T(exu_req_t)) u_exu_q (
    .rclk, .rst_n,
    .push(exu_valid), .din(exu_din), .pop(exu_pop),
    .head_valid(exu_head_valid), .head(exu_head), .credit(exu_credit)
  );

  mul_req_fifo #(.T(spu_req_t)) u_spu_q (
    .rclk, .rst_n,
    .push(spu_valid), .din(spu_din), .pop(spu_pop),
    .head_valid(spu_head_valid), .head(spu_head), .credit(spu_credit)
  );

  ////////////////////////////////////////////////////////////
  // Control, multiplier, datapath
  ////////////////////////////////////////////////////////////

  // Op tag travels inside control; the multiplier valid duplicates wb_valid
  mul_ctl u_ctl (
    .rclk, .rst_n, .exu_head_valid, .spu_head_valid, .spu_head, .res_credit,
    .exu_pop, .spu_pop, .issue, .issue_src, .issue_op(), .issue_x2, .issue_byp,
    .wb_valid, .wb_src, .wb_op
  );

  mul_core u_core (
    .rclk, .rst_n, .in_valid(issue), .op1(mul_op1), .op2(mul_op2), .x2(issue_x2),
    .prod_valid(), .prod
  );

  mul_dp u_dp (
    .rclk, .rst_n, .issue_src, .issue_byp, .exu_head, .spu_head, .mul_op1, .mul_op2,
    .wb_valid, .wb_src, .wb_op, .prod, .res_valid, .res_src, .res_data
  );

endmodule

//--- tb_mul_tasks.svh
// Included inside tb_mul_unit after its declarations; every task starts and ends on a falling edge
`ifndef TB_MUL_TASKS_SVH
`define TB_MUL_TASKS_SVH

////////////////////////////////////////////////////////////
// Compare and abort
////////////////////////////////////////////////////////////

task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    mismatches++;
    $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_src(input src_e got, input src_e exp, input string what);
  if (got !== exp) begin
    mismatches++;
    $display("MISMATCH @%0t: %s got tag %b expected tag %b", $time, what, got, exp);
  end
endtask

task automatic abort_run(input string what);
  timeouts++;
  $display("Timed out at %0t while waiting for %s", $time, what);
  finish_run();
endtask

////////////////////////////////////////////////////////////
// Drivers
////////////////////////////////////////////////////////////

task automatic send_exu(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
  int                waited;
  logic [PROD_W-1:0] p;
  waited = 0;
  while (REQ_DEPTH + exu_back - exu_spent <= 0 && waited < TIMEOUT) begin
    @(negedge rclk);
    waited++;
  end
  if (REQ_DEPTH + exu_back - exu_spent <= 0) begin
    abort_run("an EXU input credit");
  end else begin
    p = PROD_W'(a) * PROD_W'(b);
    exp_exu.push_back(p[DATA_W-1:0]);     // Low half of the product
    exu_valid = 1'b1;
    exu_op1   = a;
    exu_op2   = b;
    @(negedge rclk);
    exu_valid = 1'b0;
  end
endtask

task automatic send_spu(input mul_op_e op, input logic [DATA_W-1:0] a,
                        input logic [DATA_W-1:0] b, input logic x2, input logic byp);
  int waited;
  waited = 0;
  while (REQ_DEPTH + spu_back - spu_spent <= 0 && waited < TIMEOUT) begin
    @(negedge rclk);
    waited++;
  end
  if (REQ_DEPTH + spu_back - spu_spent <= 0) begin
    abort_run("an SPU input credit");
  end else begin
    exp_spu.push_back(model_spu(op, a, b, x2, byp));
    spu_valid = 1'b1;
    spu_op1   = a;
    spu_op2   = b;
    spu_op    = op;
    spu_x2    = x2;
    spu_byp   = byp;
    @(negedge rclk);
    spu_valid = 1'b0;
  end
endtask

////////////////////////////////////////////////////////////
// Result collection
////////////////////////////////////////////////////////////

function automatic bit results_pending();
  return got_exu.size() < exp_exu.size() || got_spu.size() < exp_spu.size()
         || res_freed != res_seen;
endfunction

// Waits for every expected result and credit, then compares in source order
task automatic settle_results(input string what);
  int waited;
  waited = 0;
  while (results_pending() && waited < TIMEOUT) begin
    @(negedge rclk);
    waited++;
  end
  if (results_pending()) begin
    abort_run({"results of ", what});
  end else begin
    while (exp_exu.size() > 0) check_data(got_exu.pop_front(), exp_exu.pop_front(), what);
    while (exp_spu.size() > 0) check_data(got_spu.pop_front(), exp_spu.pop_front(), what);
    if (got_exu.size() != 0 || got_spu.size() != 0) begin
      other_errors++;
      $display("Unexpected extra results after %s at %0t", what, $time);
      got_exu.delete();
      got_spu.delete();
    end
  end
endtask

task automatic verify_tags(input src_e src, input string what);
  while (got_tag.size() > 0) check_src(got_tag.pop_front(), src, what);
endtask

////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////

task automatic after_reset();
  check_data(DATA_W'(res_valid), '0, "res_valid after reset");
  check_data(DATA_W'(exu_credit), '0, "exu_credit after reset");
  check_data(DATA_W'(spu_credit), '0, "spu_credit after reset");
  send_spu(OP_RDSHF, '0, '0, 1'b0, 1'b0);   // Empty accumulator reads zero
  settle_results("RDSHF after reset");
  verify_tags(SRC_SPU, "RDSHF after reset tag");
endtask

task automatic exu_products();
  for (int i = 0; i < 6; i++) begin
    send_exu({$urandom, $urandom}, {$urandom, $urandom});
  end
  send_exu('1, '1);                         // Largest product
  settle_results("EXU multiply");
  verify_tags(SRC_EXU, "EXU multiply tag");
endtask

task automatic acc_sequence();
  send_spu(OP_CLR, '0, '0, 1'b0, 1'b0);
  send_spu(OP_MAC, 64'hffff_ffff_ffff_fffb, 64'hffff_ffff_ffff_fff7, 1'b0, 1'b0);
  send_spu(OP_MAC, 64'hfedc_ba98_7654_3210, 64'hf0f0_f0f0_0f0f_0f0f, 1'b1, 1'b0);
  send_spu(OP_RDSHF, '0, '0, 1'b0, 1'b0);
  send_spu(OP_RDSHF, '0, '0, 1'b0, 1'b0);
  send_spu(OP_RDSHF, '0, '0, 1'b0, 1'b0);   // Bits above 128
  send_spu(OP_MUL, {$urandom, $urandom}, {$urandom, $urandom}, 1'b1, 1'b0);
  settle_results("accumulator sequence");
  verify_tags(SRC_SPU, "accumulator sequence tag");
endtask

task automatic acc_bypass();
  send_spu(OP_CLR, '0, '0, 1'b0, 1'b0);
  send_spu(OP_MAC, 64'h0000_0001_2345_6789, 64'h0000_0000_9abc_def1, 1'b0, 1'b0);
  send_spu(OP_MUL, 64'h1111_2222_3333_4444, 64'hdead_beef_dead_beef, 1'b0, 1'b1);
  send_spu(OP_MAC, 64'h0000_0000_0000_0003, 64'h5555_5555_5555_5555, 1'b1, 1'b1);
  send_spu(OP_RDSHF, '0, '0, 1'b0, 1'b0);
  settle_results("accumulator bypass");
  verify_tags(SRC_SPU, "accumulator bypass tag");
endtask

task automatic back_pressure();
  int base;
  int waited;
  int extra;
  auto_credit = 1'b0;                       // Consumer keeps every credit
  base        = res_seen;
  waited      = 0;
  extra       = 0;
  for (int i = 0; i < RES_CREDITS + REQ_DEPTH; i++) begin
    send_exu({$urandom, $urandom}, {$urandom, $urandom});
  end
  for (int i = 0; i < REQ_DEPTH; i++) begin
    send_spu(OP_MUL, {$urandom, $urandom}, {$urandom, $urandom}, i == 1, 1'b0);
  end
  while (res_seen - base < RES_CREDITS && waited < TIMEOUT) begin
    @(negedge rclk);
    waited++;
  end
  if (res_seen - base < RES_CREDITS) begin
    abort_run("results under back-pressure");
  end else begin
    repeat (4 * MUL_LAT) begin
      @(negedge rclk);
      if (res_seen - base > RES_CREDITS) extra++;
    end
    if (extra != 0) begin
      other_errors++;
      $display("More than %0d results arrived without result credits", RES_CREDITS);
    end
    if (REQ_DEPTH + exu_back - exu_spent != 0 || REQ_DEPTH + spu_back - spu_spent != 0) begin
      other_errors++;
      $display("Input credit came back while both queues should be full at %0t", $time);
    end
    auto_credit = 1'b1;
    settle_results("back-pressure release");
    got_tag.delete();
  end
endtask

task automatic mixed_traffic();
  logic [DATA_W-1:0] a [16];
  logic [DATA_W-1:0] b [16];
  for (int i = 0; i < 16; i++) begin
    a[i] = {$urandom, $urandom};
    b[i] = {$urandom, $urandom};
  end
  fork
    begin
      for (int i = 0; i < 8; i++) begin
        send_exu(a[i], b[i]);
      end
    end
    begin
      send_spu(OP_CLR, '0, '0, 1'b0, 1'b0);
      for (int j = 0; j < 8; j++) begin
        send_spu(j % 3 == 0 ? OP_MUL : (j % 3 == 1 ? OP_MAC : OP_RDSHF),
                 a[8+j], b[8+j], j[1], j[0]);
      end
    end
  join
  settle_results("mixed traffic");
  got_tag.delete();
endtask

`endif

//--- tb_mul_unit.sv
// Directed tests only; inputs change on the falling edge and DUT outputs are sampled on the rising edge
`timescale 1ns/1ns

module tb_mul_unit;

  import mul_pkg::*;

  localparam int TIMEOUT = 200;         // Cycles allowed per wait loop
  localparam int EXT_W   = PROD_W + 1;  // Product width with doubling

  logic              rclk;
  logic              rst_n;
  logic              exu_valid;
  logic [DATA_W-1:0] exu_op1;
  logic [DATA_W-1:0] exu_op2;
  logic              exu_credit;
  logic              spu_valid;
  logic [DATA_W-1:0] spu_op1;
  logic [DATA_W-1:0] spu_op2;
  mul_op_e           spu_op;
  logic              spu_x2;
  logic              spu_byp;
  logic              spu_credit;
  logic              res_valid;
  src_e              res_src;
  logic [DATA_W-1:0] res_data;
  logic              res_credit;

  // Counters and queues below change only on the rising edge
  int                exu_spent;     // EXU valid cycles seen
  int                exu_back;      // EXU credit pulses seen
  int                spu_spent;
  int                spu_back;
  int                res_seen;      // Results taken
  int                res_freed;     // Result credits handed back
  logic              auto_q;        // Sampled copy of auto_credit
  logic [DATA_W-1:0] got_exu [$];
  logic [DATA_W-1:0] got_spu [$];
  src_e              got_tag [$];

  logic              auto_credit;   // Consumer returns credits by itself
  logic [DATA_W-1:0] exp_exu [$];
  logic [DATA_W-1:0] exp_spu [$];
  logic [ACC_W-1:0]  acc_m;         // Reference accumulator
  int                mismatches;
  int                timeouts;
  int                other_errors;

  mul_unit dut_i (.*);

  initial rclk = 1'b0;
  always #20 rclk = ~rclk;          // 40 ns period

  ////////////////////////////////////////////////////////////
  // Monitor and consumer
  ////////////////////////////////////////////////////////////

  always @(posedge rclk) begin
    auto_q = auto_credit;
    if (rst_n) begin
      if (exu_valid)  exu_spent++;
      if (exu_credit) exu_back++;
      if (spu_valid)  spu_spent++;
      if (spu_credit) spu_back++;
      if (res_credit) res_freed++;
      if (res_valid) begin
        res_seen++;
        got_tag.push_back(res_src);
        if (res_src == SRC_EXU) got_exu.push_back(res_data);
        else                    got_spu.push_back(res_data);
      end
    end
  end

  // One credit per cycle while any are owed
  always @(negedge rclk) begin
    res_credit = auto_q && (res_seen > res_freed);
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Called in SPU request order, so byp sees the accumulator as of issue
  function automatic logic [DATA_W-1:0] model_spu(input mul_op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
      input logic x2, input logic byp);
    logic [EXT_W-1:0]  p;
    logic [DATA_W-1:0] r;
    p = EXT_W'(a) * EXT_W'(byp ? acc_m[DATA_W-1:0] : b);
    if (x2) p = p << 1;
    case (op)
      OP_MUL: r = p[DATA_W-1:0];
      OP_MAC: begin
        acc_m = acc_m + ACC_W'(p);   // Wraps at ACC_W
        r     = acc_m[DATA_W-1:0];
      end
      OP_RDSHF: begin
        r     = acc_m[DATA_W-1:0];   // Old low half
        acc_m = acc_m >> DATA_W;
      end
      default: begin
        r     = '0;
        acc_m = '0;
      end
    endcase
    return r;
  endfunction

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
             other_errors);
    if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  `include "tb_mul_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h4be9bece));
    rst_n        = 1'b0;
    exu_valid    = 1'b0;
    exu_op1      = '0;
    exu_op2      = '0;
    spu_valid    = 1'b0;
    spu_op1      = '0;
    spu_op2      = '0;
    spu_op       = OP_MUL;
    spu_x2       = 1'b0;
    spu_byp      = 1'b0;
    res_credit   = 1'b0;
    auto_credit  = 1'b1;
    auto_q       = 1'b0;
    exu_spent    = 0;
    exu_back     = 0;
    spu_spent    = 0;
    spu_back     = 0;
    res_seen     = 0;
    res_freed    = 0;
    acc_m        = '0;
    mismatches   = 0;
    timeouts     = 0;
    other_errors = 0;
    repeat (10) @(posedge rclk);     // Reset over ten rising edges
    @(negedge rclk);
    rst_n = 1'b1;
    after_reset();
    exu_products();
    acc_sequence();
    acc_bypass();
    back_pressure();
    mixed_traffic();
    finish_run();
  end

endmodule

//--- sim.f
+incdir+.
mul_pkg.sv
mul_req_fifo.sv
mul_ctl.sv
mul_core.sv
mul_dp.sv
mul_unit.sv
tb_mul_unit.sv

//--- Bender.yml
package:
  name: mul_unit

sources:
  # Design, in compile order
  - files:
      - mul_pkg.sv
      - mul_req_fifo.sv
      - mul_ctl.sv
      - mul_core.sv
      - mul_dp.sv
      - mul_unit.sv

  # Testbench, with the folder of its included task file
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mul_unit.sv
